// File: files.f
+incdir+.
mipsPkg.sv
instructionFetch.sv
registerFile.sv
alu.sv
controlDecoder.sv
dataMemory.sv
mipsCore.sv
tbMips.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = tbMips
RTL_TOP = mipsCore
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILE_LIST)) mipsModel.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^Test passed$$' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mipsModel.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

word_t modelRegs [32];
word_t modelMem [2**DmemDepthLog2];
word_t modelPc;

// Executes the instruction at modelPc and reports the register write it makes
task automatic modelStep(output logic we, output regAddr_t rd, output word_t value);
	word_t ir;
	word_t rs;
	word_t rt;
	word_t immS;
	word_t immZ;
	word_t seqPc;
	word_t addr;
	logic [5:0] op;
	ir = prog[modelPc[7:2]];
	op = ir[31:26];
	rs = modelRegs[ir[25:21]];
	rt = modelRegs[ir[20:16]];
	immS = {{16{ir[15]}}, ir[15:0]};
	immZ = {16'h0, ir[15:0]};
	seqPc = modelPc + 32'd4;
	addr = rs + immS;
	we = 1'b1;
	rd = ir[20:16];
	value = '0;
	modelPc = seqPc;
	case (op)
		OpSpecial: begin
			rd = ir[15:11];
			case (ir[5:0])
				FnAdd, FnAddu: value = rs + rt;
				FnSub, FnSubu: value = rs - rt;
				FnAnd: value = rs & rt;
				FnOr: value = rs | rt;
				FnXor: value = rs ^ rt;
				FnNor: value = ~(rs | rt);
				FnSlt: value = {31'b0, $signed(rs) < $signed(rt)};
				FnSltu: value = {31'b0, rs < rt};
				FnSll: value = rt << ir[10:6];
				FnSrl: value = rt >> ir[10:6];
				FnSra: value = $signed(rt) >>> ir[10:6];
				default: we = 1'b0;
			endcase
		end
		OpAddi, OpAddiu: value = rs + immS;
		OpSlti: value = {31'b0, $signed(rs) < $signed(immS)};
		OpSltiu: value = {31'b0, rs < immS}; // Unsigned against sign-extended imm
		OpAndi: value = rs & immZ;
		OpOri: value = rs | immZ;
		OpXori: value = rs ^ immZ;
		OpLui: value = {ir[15:0], 16'h0};
		OpLw: value = modelMem[addr[DmemDepthLog2+1:2]];
		OpSw: begin
			modelMem[addr[DmemDepthLog2+1:2]] = rt;
			we = 1'b0;
		end
		OpBeq: begin
			we = 1'b0;
			if (rs == rt) modelPc = seqPc + (immS << 2);
		end
		OpBne: begin
			we = 1'b0;
			if (rs != rt) modelPc = seqPc + (immS << 2);
		end
		OpJ: begin
			we = 1'b0;
			modelPc = {seqPc[31:28], ir[25:0], 2'b00};
		end
		default: we = 1'b0;
	endcase
	if (rd == 5'd0) we = 1'b0; // $zero never changes
	if (we) modelRegs[rd] = value;
endtask

`endif

// File: tbMips.sv
`timescale 1ns/1ns

module tbMips;
	import mipsPkg::*;

	localparam int ProgLen = 64;
	localparam int RunCycles = 100;
	localparam int NumTests = 8;
	localparam int ClkPeriod = 4;

	logic Clk = 1'b0;
	logic rst;
	logic run;
	logic load;
	logic [ImemDepthLog2-1:0] loadAddr;
	word_t loadData;
	word_t pc;
	retire_t retire;

	word_t prog [ProgLen];
	word_t lfsr;
	int errors;
	int testErrors;
	int failedTests;
	int testCount;

	funct_t rFuncts [13] = '{FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr, FnXor, FnNor,
		FnSlt, FnSltu, FnSll, FnSrl, FnSra}; // Shifts last
	opcode_t iOps [8] = '{OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};

	`include "mipsModel.svh"

	mipsCore dut0 (
		.Clk(Clk),
		.rst(rst),
		.run(run),
		.load(load),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.pc(pc),
		.retire(retire)
	);

	always #(ClkPeriod / 2) Clk = ~Clk;

	function automatic word_t lfsrStep(input word_t s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t randBits(input int count);
		word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return value;
	endfunction

	function automatic word_t rType(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt,
			logic [4:0] sh);
		return {OpSpecial, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(logic [25:0] target);
		return {OpJ, target};
	endfunction

	// kind 0 is ALU only, 1 adds branches and jumps, 2 adds loads and stores
	function automatic word_t randomWord(input int idx, input int kind);
		int aluSel;
		int cat;
		int fwd;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [15:0] imm;
		aluSel = randBits(5) % 21;
		cat = (kind == 0) ? 0 : randBits(4);
		fwd = randBits(6) % (ProgLen - 1 - idx); // Target stays inside the program
		rs = regAddr_t'(randBits(5));
		rt = regAddr_t'(randBits(5));
		rd = regAddr_t'(randBits(5));
		imm = 16'(randBits(16));
		if ((cat == 13 || cat == 14) && imm[0]) rt = rs; // Flip the branch outcome
		if (kind == 2 && (cat == 9 || cat == 10)) return iType(OpLw, 5'd0, rt, {imm[5:2], 2'b00});
		if (kind == 2 && (cat == 11 || cat == 12)) return iType(OpSw, 5'd0, rt, {imm[5:2], 2'b00});
		if (cat == 13) return iType(OpBeq, rs, rt, 16'(fwd));
		if (cat == 14) return iType(OpBne, rs, rt, 16'(fwd));
		if (cat == 15) return jType(26'(idx + 1 + fwd));
		if (aluSel < 13) return rType(rFuncts[aluSel], rd, rs, rt, (aluSel >= 10) ? imm[4:0] : 5'd0);
		return iType(iOps[aluSel - 13], rs, rt, imm);
	endfunction

	task automatic buildProgram(input int kind);
		for (int i = 0; i < ProgLen - 1; i++) begin
			prog[i] = randomWord(i, kind);
		end
		prog[ProgLen - 1] = jType(26'(ProgLen - 1)); // Parks the core
	endtask

	task automatic buildMemProgram();
		for (int i = 0; i < 16; i++) begin
			prog[i] = iType(OpSw, 5'd0, regAddr_t'(randBits(5) % 31 + 1), 16'(i * 4));
			prog[i + 16] = iType(OpLw, 5'd0, regAddr_t'(randBits(5) % 31 + 1), 16'(i * 4));
		end
		for (int i = 32; i < ProgLen - 1; i++) begin
			prog[i] = '0;
		end
		prog[ProgLen - 1] = jType(26'(ProgLen - 1));
	endtask

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			errors++;
			testErrors++;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (testErrors == 0) begin
			$display("[%0d] %s: ok", testCount, name);
		end else begin
			failedTests++;
			$display("[%0d] %s: FAIL with %0d mismatches", testCount, name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < ProgLen; i++) begin
			@(posedge Clk);
			load <= 1'b1;
			loadAddr <= ImemDepthLog2'(i);
			loadData <= prog[i];
		end
		@(posedge Clk);
		load <= 1'b0;
	endtask

	task automatic runProgram();
		logic expWe;
		regAddr_t expRd;
		word_t expData;
		word_t expPc;
		modelPc = '0;
		@(posedge Clk);
		run <= 1'b1;
		for (int c = 0; c < RunCycles; c++) begin
			@(negedge Clk); // Retire is settled mid-cycle
			expPc = modelPc;
			modelStep(expWe, expRd, expData);
			check("pc", 64'(pc), 64'(expPc));
			check("retire we", 64'(retire.we), 64'(expWe));
			if (expWe) begin
				check("retire rd", 64'(retire.rd), 64'(expRd));
				check("retire data", 64'(retire.data), 64'(expData));
			end
		end
		@(posedge Clk);
		run <= 1'b0;
	endtask

	initial begin
		#(NumTests * (ProgLen + 200) * ClkPeriod);
		$display("Watchdog expired: the tests did not finish in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		lfsr = 32'h52e5_7d2a;
		errors = 0;
		testErrors = 0;
		failedTests = 0;
		testCount = 0;
		rst = 1'b1;
		run = 1'b0;
		load = 1'b0;
		loadAddr = '0;
		loadData = '0;
		modelRegs[0] = '0;
		repeat (4) @(posedge Clk);
		rst <= 1'b0;
		repeat (5) begin
			@(negedge Clk);
			check("reset pc", 64'(pc), 64'd0);
			check("reset retire we", 64'(retire.we), 64'd0);
		end
		endTest("reset state");

		buildProgram(0);
		for (int i = 0; i < 31; i++) begin
			prog[i] = iType(OpAddiu, 5'd0, regAddr_t'(i + 1), 16'(randBits(16))); // Seed regs
		end
		prog[31] = iType(OpAddiu, 5'd1, 5'd0, 16'h1234); // Writes aimed at $zero
		prog[32] = rType(FnOr, 5'd0, 5'd1, 5'd2, 5'd0);
		loadProgram();
		runProgram();
		endTest("ALU results");

		buildMemProgram();
		loadProgram();
		runProgram();
		endTest("store then load");

		buildProgram(1);
		loadProgram();
		runProgram();
		endTest("branches and jump");

		for (int t = 0; t < 4; t++) begin
			buildProgram(2);
			loadProgram();
			runProgram();
			endTest($sformatf("random mixed program %0d", t));
		end

		$display("%0d tests run, %0d failed, %0d mismatches", testCount, failedTests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: mipsCore.sv
`timescale 1ns/1ns

module mipsCore (
	input logic Clk,
	input logic rst,
	input logic run,
	input logic load,
	input logic [mipsPkg::ImemDepthLog2-1:0] loadAddr,
	input mipsPkg::word_t loadData,
	output mipsPkg::word_t pc,
	output mipsPkg::retire_t retire
);
	import mipsPkg::*;

	word_t instruction;
	word_t readDataA;
	word_t readDataB;
	word_t immExt;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	word_t memData;
	regAddr_t destReg;
	ctrl_t ctrl;
	logic zero;

	instructionFetch fetch0 (
		.Clk(Clk),
		.rst(rst),
		.run(run),
		.load(load),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.branchEq(ctrl.branchEq),
		.branchNe(ctrl.branchNe),
		.jump(ctrl.jump),
		.zero(zero),
		.instruction(instruction),
		.pc(pc)
	);

	controlDecoder decoder0 (
		.instruction(instruction),
		.ctrl(ctrl)
	);

	registerFile regFile0 (
		.Clk(Clk),
		.readAddrA(instruction[25:21]), // rs
		.readAddrB(instruction[20:16]), // rt
		.write(retire),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	assign immExt = ctrl.signExt ? {{16{instruction[15]}}, instruction[15:0]}
		: {16'b0, instruction[15:0]};
	assign aluA = ctrl.shiftSrc ? {{(DataWidth-5){1'b0}}, instruction[10:6]} : readDataA;
	assign aluB = ctrl.immSrc ? immExt : readDataB;

	alu alu0 (
		.op(ctrl.aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	dataMemory dmem0 (
		.Clk(Clk),
		.write(run && ctrl.memWrite),
		.addr(aluResult),
		.writeData(readDataB),
		.readData(memData)
	);

	assign destReg = ctrl.regDst ? instruction[15:11] : instruction[20:16];

	assign retire = '{
		we: run && ctrl.regWrite && (destReg != '0), // $zero writes never retire
		rd: destReg,
		data: ctrl.memRead ? memData : aluResult
	};

endmodule

// File: dataMemory.sv
`timescale 1ns/1ns

module dataMemory (
	input logic Clk,
	input logic write,
	input mipsPkg::word_t addr,
	input mipsPkg::word_t writeData,
	output mipsPkg::word_t readData
);
	import mipsPkg::*;

	word_t mem [2**DmemDepthLog2];
	logic [DmemDepthLog2-1:0] index;

	assign index = addr[DmemDepthLog2+1:2]; // Byte address to word index

	always_ff @(posedge Clk) begin
		if (write) begin
			mem[index] <= writeData;
		end
	end

	assign readData = mem[index];

endmodule

// File: controlDecoder.sv
`timescale 1ns/1ns

module controlDecoder (
	input mipsPkg::word_t instruction,
	output mipsPkg::ctrl_t ctrl
);
	import mipsPkg::*;

	always_comb begin
		ctrl = '0; // No-op unless decoded below
		if (instruction != '0) begin
			case (opcode_t'(instruction[31:26]))
				OpSpecial: begin
					ctrl.regDst = 1'b1;
					ctrl.regWrite = 1'b1;
					case (funct_t'(instruction[5:0]))
						FnAdd, FnAddu: ctrl.aluOp = AluAdd;
						FnSub, FnSubu: ctrl.aluOp = AluSub;
						FnAnd: ctrl.aluOp = AluAnd;
						FnOr: ctrl.aluOp = AluOr;
						FnXor: ctrl.aluOp = AluXor;
						FnNor: ctrl.aluOp = AluNor;
						FnSlt: ctrl.aluOp = AluSlt;
						FnSltu: ctrl.aluOp = AluSltu;
						FnSll: begin
							ctrl.aluOp = AluSll;
							ctrl.shiftSrc = 1'b1;
						end
						FnSrl: begin
							ctrl.aluOp = AluSrl;
							ctrl.shiftSrc = 1'b1;
						end
						FnSra: begin
							ctrl.aluOp = AluSra;
							ctrl.shiftSrc = 1'b1;
						end
						default: ctrl = '0; // Unknown funct
					endcase
				end
				OpAddi, OpAddiu: begin
					ctrl.aluOp = AluAdd;
					ctrl.immSrc = 1'b1;
					ctrl.signExt = 1'b1;
					ctrl.regWrite = 1'b1;
				end
				OpSlti, OpSltiu: begin
					// Both compare against the sign-extended immediate
					ctrl.aluOp = (instruction[26]) ? AluSltu : AluSlt;
					ctrl.immSrc = 1'b1;
					ctrl.signExt = 1'b1;
					ctrl.regWrite = 1'b1;
				end
				OpAndi, OpOri, OpXori, OpLui: begin
					case (opcode_t'(instruction[31:26]))
						OpAndi: ctrl.aluOp = AluAnd;
						OpOri: ctrl.aluOp = AluOr;
						OpXori: ctrl.aluOp = AluXor;
						default: ctrl.aluOp = AluLui;
					endcase
					ctrl.immSrc = 1'b1; // Zero-extended
					ctrl.regWrite = 1'b1;
				end
				OpLw: begin
					ctrl.aluOp = AluAdd;
					ctrl.immSrc = 1'b1;
					ctrl.signExt = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.regWrite = 1'b1;
				end
				OpSw: begin
					ctrl.aluOp = AluAdd;
					ctrl.immSrc = 1'b1;
					ctrl.signExt = 1'b1;
					ctrl.memWrite = 1'b1;
				end
				OpBeq: begin
					ctrl.aluOp = AluSub;
					ctrl.branchEq = 1'b1;
				end
				OpBne: begin
					ctrl.aluOp = AluSub;
					ctrl.branchNe = 1'b1;
				end
				OpJ: ctrl.jump = 1'b1;
				default: ctrl = '0;
			endcase
		end
	end

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu (
	input mipsPkg::aluOp_t op,
	input mipsPkg::word_t a,
	input mipsPkg::word_t b,
	output mipsPkg::word_t result,
	output logic zero
);
	import mipsPkg::*;

	always_comb begin
		case (op)
			AluAnd: result = a & b;
			AluOr: result = a | b;
			AluXor: result = a ^ b;
			AluNor: result = ~(a | b);
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluSlt: result = {{(DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
			AluSltu: result = {{(DataWidth-1){1'b0}}, a < b};
			AluSll: result = b << a[4:0]; // Amount from low bits of a
			AluSrl: result = b >> a[4:0];
			AluSra: result = $signed(b) >>> a[4:0];
			AluLui: result = {b[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: registerFile.sv
`timescale 1ns/1ns

module registerFile (
	input logic Clk,
	input mipsPkg::regAddr_t readAddrA,
	input mipsPkg::regAddr_t readAddrB,
	input mipsPkg::retire_t write,
	output mipsPkg::word_t readDataA,
	output mipsPkg::word_t readDataB
);
	import mipsPkg::*;

	word_t regs [1:2**RegAddrWidth-1]; // No storage for $zero

	always_ff @(posedge Clk) begin
		if (write.we && write.rd != '0) begin
			regs[write.rd] <= write.data;
		end
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: instructionFetch.sv
`timescale 1ns/1ns

module instructionFetch (
	input logic Clk,
	input logic rst,
	input logic run,
	input logic load,
	input logic [mipsPkg::ImemDepthLog2-1:0] loadAddr,
	input mipsPkg::word_t loadData,
	input logic branchEq,
	input logic branchNe,
	input logic jump,
	input logic zero,
	output mipsPkg::word_t instruction,
	output mipsPkg::word_t pc
);
	import mipsPkg::*;

	word_t imem [2**ImemDepthLog2];
	word_t pcSeq;
	word_t pcBranch;
	word_t pcJump;
	word_t pcNext;
	logic taken;

	always_ff @(posedge Clk) begin
		if (load) begin
			imem[loadAddr] <= loadData;
		end
	end

	assign instruction = imem[pc[ImemDepthLog2+1:2]]; // Word index of pc

	assign pcSeq = pc + 32'd4;
	assign pcBranch = pcSeq + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	assign pcJump = {pcSeq[31:28], instruction[25:0], 2'b00};
	assign taken = (branchEq & zero) | (branchNe & ~zero);

	always_comb begin
		if (jump) begin
			pcNext = pcJump;
		end else if (taken) begin
			pcNext = pcBranch;
		end else begin
			pcNext = pcSeq;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst || !run) begin
			pc <= '0; // Held at the reset vector
		end else begin
			pc <= pcNext;
		end
	end

endmodule

// File: mipsPkg.sv
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int ImemDepthLog2 = 8; // 256 instruction words
	localparam int DmemDepthLog2 = 8;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	typedef enum logic [5:0] {
		OpSpecial = 6'd0,
		OpJ = 6'd2,
		OpBeq = 6'd4,
		OpBne = 6'd5,
		OpAddi = 6'd8,
		OpAddiu = 6'd9,
		OpSlti = 6'd10,
		OpSltiu = 6'd11,
		OpAndi = 6'd12,
		OpOri = 6'd13,
		OpXori = 6'd14,
		OpLui = 6'd15,
		OpLw = 6'd35,
		OpSw = 6'd43
	} opcode_t;

	typedef enum logic [5:0] {
		FnSll = 6'd0,
		FnSrl = 6'd2,
		FnSra = 6'd3,
		FnAdd = 6'd32,
		FnAddu = 6'd33,
		FnSub = 6'd34,
		FnSubu = 6'd35,
		FnAnd = 6'd36,
		FnOr = 6'd37,
		FnXor = 6'd38,
		FnNor = 6'd39,
		FnSlt = 6'd42,
		FnSltu = 6'd43
	} funct_t;

	typedef enum logic [3:0] {
		AluAnd,
		AluOr,
		AluXor,
		AluNor,
		AluAdd,
		AluSub,
		AluSlt,
		AluSltu,
		AluSll,
		AluSrl,
		AluSra,
		AluLui
	} aluOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic shiftSrc; // Shamt field as operand A
		logic immSrc; // Immediate as operand B
		logic signExt;
		logic regDst; // Write rd instead of rt
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
	} ctrl_t;

	typedef struct packed {
		logic we;
		regAddr_t rd;
		word_t data;
	} retire_t;

endpackage
